/* build.f */
+incdir+source
source/wb_pkg.sv
source/wb_arbiter.sv
source/wb_addr_decoder.sv
source/wb_shared_bus.sv
source/wb_ram_slave.sv
source/wb_bus_top.sv
verification/wb_bus_checker.sv
verification/wb_bus_tb.sv

/* Makefile */
TOP := wb_bus_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f build.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f build.f --top-module $(TOP)
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf obj_dir

/* verification/wb_bus_tb.sv */
// testbench top: clock, reset, stimulus table and the two master drivers
`timescale 1ns/1ps
`include "wb_bus_cfg.svh"

module wb_bus_tb;

    localparam int MAX_ROWS   = 24;
    localparam int WAIT_LIMIT = 40;

    logic                      clk;
    logic                      reset;
    logic [`WB_M*`WB_AW-1:0]   m_adr;
    logic [`WB_M*`WB_DW-1:0]   m_wdat;
    logic [`WB_M*`WB_SELW-1:0] m_sel;
    logic [`WB_M-1:0]          m_we;
    logic [`WB_M-1:0]          m_cyc;
    logic [`WB_M-1:0]          m_stb;
    logic [`WB_M*`WB_DW-1:0]   m_rdat;
    logic [`WB_M-1:0]          m_ack;
    logic [`WB_M-1:0]          m_err;
    logic [`WB_AW-1:0]         snoop_adr;
    logic                      snoop_en;

    // stimulus table, one access per row
    string                 row_name [MAX_ROWS];
    int                    row_mst  [MAX_ROWS];
    logic                  row_pair [MAX_ROWS];
    logic                  row_we   [MAX_ROWS];
    logic [`WB_AW-1:0]     row_adr  [MAX_ROWS];
    logic [`WB_DW-1:0]     row_dat  [MAX_ROWS];
    logic [`WB_SELW-1:0]   row_sel  [MAX_ROWS];
    logic                  row_err  [MAX_ROWS];
    int                    nrows = 0;
    integer                seed = 32'h686a0e95;

    wb_bus_top DUT (
        .clk         (clk),
        .reset       (reset),
        .m_adr_i     (m_adr),
        .m_dat_i     (m_wdat),
        .m_sel_i     (m_sel),
        .m_we_i      (m_we),
        .m_cyc_i     (m_cyc),
        .m_stb_i     (m_stb),
        .m_dat_o     (m_rdat),
        .m_ack_o     (m_ack),
        .m_err_o     (m_err),
        .snoop_adr_o (snoop_adr),
        .snoop_en_o  (snoop_en)
    );

    wb_bus_checker u_checker (
        .clk         (clk),
        .reset       (reset),
        .m_adr_i     (m_adr),
        .m_wdat_i    (m_wdat),
        .m_sel_i     (m_sel),
        .m_we_i      (m_we),
        .m_cyc_i     (m_cyc),
        .m_rdat_i    (m_rdat),
        .m_ack_i     (m_ack),
        .m_err_i     (m_err),
        .snoop_adr_i (snoop_adr),
        .snoop_en_i  (snoop_en)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic add_row(input string name, input int mst, input logic pair,
                           input logic we, input logic [`WB_AW-1:0] adr,
                           input logic [`WB_SELW-1:0] sel, input logic err);
        row_name[nrows] = name;
        row_mst[nrows]  = mst;
        row_pair[nrows] = pair;
        row_we[nrows]   = we;
        row_adr[nrows]  = adr;
        row_dat[nrows]  = $random(seed);
        row_sel[nrows]  = sel;
        row_err[nrows]  = err;
        nrows++;
    endtask

    task automatic build_table();
        // simultaneous pair from idle, master 0 has priority
        add_row("pair_wr_s0",   0, 1'b1, 1'b1, 32'h0000_0100, 4'hf, 1'b0);
        add_row("pair_rd_s0",   0, 1'b1, 1'b0, 32'h0000_0100, 4'hf, 1'b0);
        // same offset in all three slaves
        add_row("wr_s0",        0, 1'b0, 1'b1, 32'h0000_0010, 4'hf, 1'b0);
        add_row("wr_s1",        1, 1'b0, 1'b1, 32'h0000_1010, 4'hf, 1'b0);
        add_row("wr_s2",        0, 1'b0, 1'b1, 32'h0000_2010, 4'hf, 1'b0);
        add_row("rd_s0",        1, 1'b0, 1'b0, 32'h0000_0010, 4'hf, 1'b0);
        add_row("rd_s1",        0, 1'b0, 1'b0, 32'h0000_1010, 4'hf, 1'b0);
        add_row("rd_s2",        1, 1'b0, 1'b0, 32'h0000_2010, 4'hf, 1'b0);
        // byte lane merge
        add_row("wr_full_s1",   0, 1'b0, 1'b1, 32'h0000_1020, 4'hf, 1'b0);
        add_row("wr_part_s1",   1, 1'b0, 1'b1, 32'h0000_1020, 4'h5, 1'b0);
        add_row("rd_merge_s1",  0, 1'b0, 1'b0, 32'h0000_1020, 4'hf, 1'b0);
        // unmapped holes must not touch word 0 of slave 0
        add_row("wr_base_s0",   1, 1'b0, 1'b1, 32'h0000_0000, 4'hf, 1'b0);
        add_row("wr_hole_s0",   0, 1'b0, 1'b1, 32'h0000_0400, 4'hf, 1'b1);
        add_row("wr_no_slave",  1, 1'b0, 1'b1, 32'h0000_3000, 4'hf, 1'b1);
        add_row("rd_map_top",   0, 1'b0, 1'b0, 32'hffff_fff0, 4'hf, 1'b1);
        add_row("rd_base_s0",   1, 1'b0, 1'b0, 32'h0000_0000, 4'hf, 1'b0);
        // master 0 wins last, so master 1 leads the next pair
        add_row("solo_m0",      0, 1'b0, 1'b0, 32'h0000_0010, 4'hf, 1'b0);
        add_row("pair_wr_s2",   0, 1'b1, 1'b1, 32'h0000_2100, 4'hf, 1'b0);
        add_row("pair_rd_s2",   0, 1'b1, 1'b0, 32'h0000_2100, 4'hf, 1'b0);
    endtask

    task automatic abort_on_timeout(input int m, input string name);
        $display("timeout: master %0d got neither ack nor err within %0d cycles in %s",
                 m, WAIT_LIMIT, name);
        u_checker.print_counts();
        $display("TB FAILED");
        $finish;
    endtask

    // one classic single access, called just after a rising edge
    task automatic run_access(input int m, input string name, input logic we,
                              input logic [`WB_AW-1:0] adr, input logic [`WB_DW-1:0] dat,
                              input logic [`WB_SELW-1:0] sel, input logic err);
        int waited;
        u_checker.test_name[m] = name;
        u_checker.exp_err[m]   = err;
        m_adr[m*`WB_AW +: `WB_AW]       = adr;
        m_wdat[m*`WB_DW +: `WB_DW]      = dat;
        m_sel[m*`WB_SELW +: `WB_SELW]   = sel;
        m_we[m]  = we;
        m_cyc[m] = 1'b1;
        m_stb[m] = 1'b1;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!(m_ack[m] || m_err[m]) && waited < WAIT_LIMIT);
        if (!(m_ack[m] || m_err[m])) begin
            abort_on_timeout(m, name);
        end else begin
            // drop the cycle after the response
            @(posedge clk);
            #1;
            m_cyc[m] = 1'b0;
            m_stb[m] = 1'b0;
            m_we[m]  = 1'b0;
        end
    endtask

    initial begin
        int other;
        reset  = 1'b1;
        m_adr  = '0;
        m_wdat = '0;
        m_sel  = '0;
        m_we   = '0;
        m_cyc  = '0;
        m_stb  = '0;
        build_table();
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        for (int r = 0; r < nrows; r++) begin
            @(posedge clk);
            #1;
            other = `WB_M - 1 - row_mst[r];
            if (row_pair[r]) begin
                // partner raises cyc in the same cycle, next word up
                fork
                    run_access(row_mst[r], row_name[r], row_we[r], row_adr[r],
                               row_dat[r], row_sel[r], row_err[r]);
                    run_access(other, {row_name[r], "_partner"}, row_we[r],
                               row_adr[r] + 32'd4, ~row_dat[r], row_sel[r], row_err[r]);
                join
            end else begin
                run_access(row_mst[r], row_name[r], row_we[r], row_adr[r],
                           row_dat[r], row_sel[r], row_err[r]);
            end
        end
        repeat (3) @(posedge clk);
        u_checker.print_counts();
        if (u_checker.value_errs + u_checker.other_errs == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* verification/wb_bus_checker.sv */
// testbench checker: reference memory, response, arbitration order and snoop checks
`timescale 1ns/1ps
`include "wb_bus_cfg.svh"

module wb_bus_checker (
    input logic                      clk,
    input logic                      reset,
    input logic [`WB_M*`WB_AW-1:0]   m_adr_i,
    input logic [`WB_M*`WB_DW-1:0]   m_wdat_i,
    input logic [`WB_M*`WB_SELW-1:0] m_sel_i,
    input logic [`WB_M-1:0]          m_we_i,
    input logic [`WB_M-1:0]          m_cyc_i,
    input logic [`WB_M*`WB_DW-1:0]   m_rdat_i,
    input logic [`WB_M-1:0]          m_ack_i,
    input logic [`WB_M-1:0]          m_err_i,
    input logic [`WB_AW-1:0]         snoop_adr_i,
    input logic                      snoop_en_i
);

    // per master test name and expected err, set by the driver
    string             test_name [`WB_M];
    logic              exp_err   [`WB_M];
    // model memory keyed by word address
    logic [`WB_DW-1:0] ref_mem [int unsigned];
    longint            cycle = 0;
    longint            cyc_start [`WB_M];
    logic [`WB_M-1:0]  cyc_seen = '0;
    int                rr_next = 0;
    int                value_errs = 0;
    int                other_errs = 0;

    // address map: slave k owns the first 4*WB_RAM_WORDS bytes of window k
    function automatic logic is_unmapped(input logic [`WB_AW-1:0] adr);
        logic [`WB_AW-1:0] slot;
        logic [`WB_AW-1:0] offset;
        slot   = adr / `WB_SLAVE_SPAN;
        offset = adr % `WB_SLAVE_SPAN;
        return !(slot < `WB_S && offset < 4 * `WB_RAM_WORDS);
    endfunction

    function automatic logic [`WB_DW-1:0] merge_bytes(input logic [`WB_DW-1:0] old_w,
                                                      input logic [`WB_DW-1:0] wr_w,
                                                      input logic [`WB_SELW-1:0] sel);
        logic [`WB_DW-1:0] res;
        res = old_w;
        for (int b = 0; b < `WB_SELW; b++) begin
            if (sel[b]) begin
                res[8*b +: 8] = wr_w[8*b +: 8];
            end
        end
        return res;
    endfunction

    task automatic print_counts();
        $display("checker: %0d value mismatches, %0d other errors", value_errs, other_errs);
    endtask

    // sample mid cycle, inputs move just after the rising edge
    always @(negedge clk) begin : watch
        int unsigned       key;
        logic [`WB_AW-1:0] adr;
        logic [`WB_AW-1:0] snoop_exp_adr;
        logic [`WB_DW-1:0] old_w;
        logic [`WB_DW-1:0] rdat;
        logic              unmapped;
        logic              snoop_exp;
        string             sname;
        int                pi;
        int                pj;
        if (reset) begin
            rr_next  = 0;
            cyc_seen = '0;
            if (|m_ack_i || |m_err_i || snoop_en_i) begin
                other_errs++;
                $display("response or snoop seen while reset is high");
            end
        end else begin
            cycle++;
            for (int i = 0; i < `WB_M; i++) begin
                if (m_cyc_i[i] && !cyc_seen[i]) begin
                    cyc_start[i] = cycle;
                end
            end
            for (int i = 0; i < `WB_M; i++) begin
                if (m_ack_i[i] || m_err_i[i]) begin
                    adr = m_adr_i[i*`WB_AW +: `WB_AW];
                    key = adr >> 2;
                    pi  = (i - rr_next + `WB_M) % `WB_M;
                    // an earlier or higher priority requester should have gone first
                    for (int j = 0; j < `WB_M; j++) begin
                        pj = (j - rr_next + `WB_M) % `WB_M;
                        if (j != i && m_cyc_i[j] && (cyc_start[j] < cyc_start[i] ||
                            (cyc_start[j] == cyc_start[i] && pj < pi))) begin
                            value_errs++;
                            $display("FAILED %s: first master expected %0d actual %0d",
                                     test_name[i], j, i);
                        end
                    end
                    rr_next  = (i + 1) % `WB_M;
                    unmapped = is_unmapped(adr);
                    if (unmapped != exp_err[i]) begin
                        other_errs++;
                        $display("stimulus row %s has an err flag that contradicts the map",
                                 test_name[i]);
                    end
                    if (m_ack_i[i] && m_err_i[i]) begin
                        other_errs++;
                        $display("master %0d saw ack and err in the same cycle", i);
                    end
                    if (m_err_i[i] != unmapped) begin
                        value_errs++;
                        $display("FAILED %s: err expected %0b actual %0b",
                                 test_name[i], unmapped, m_err_i[i]);
                    end else if (m_ack_i[i] && m_we_i[i]) begin
                        old_w = ref_mem.exists(key) ? ref_mem[key] : 'x;
                        ref_mem[key] = merge_bytes(old_w, m_wdat_i[i*`WB_DW +: `WB_DW],
                                                   m_sel_i[i*`WB_SELW +: `WB_SELW]);
                    end else if (m_ack_i[i]) begin
                        rdat = m_rdat_i[i*`WB_DW +: `WB_DW];
                        if (!ref_mem.exists(key)) begin
                            other_errs++;
                            $display("%s reads a word that was never written", test_name[i]);
                        end else if (rdat !== ref_mem[key]) begin
                            value_errs++;
                            $display("FAILED %s: read data expected %h actual %h",
                                     test_name[i], ref_mem[key], rdat);
                        end
                    end
                end
            end
            // snoop follows write acks exactly
            snoop_exp     = |(m_ack_i & m_we_i);
            snoop_exp_adr = '0;
            sname         = "idle bus";
            for (int i = 0; i < `WB_M; i++) begin
                if (m_ack_i[i] && m_we_i[i]) begin
                    sname         = test_name[i];
                    snoop_exp_adr = m_adr_i[i*`WB_AW +: `WB_AW];
                end
            end
            if (snoop_en_i !== snoop_exp) begin
                value_errs++;
                $display("FAILED %s: snoop_en expected %0b actual %0b",
                         sname, snoop_exp, snoop_en_i);
            end else if (snoop_en_i && snoop_adr_i !== snoop_exp_adr) begin
                value_errs++;
                $display("FAILED %s: snoop_adr expected %h actual %h",
                         sname, snoop_exp_adr, snoop_adr_i);
            end
            cyc_seen = m_cyc_i;
        end
    end

endmodule

/* source/wb_bus_top.sv */
// top level: shared bus, address decoder and one ram slave per slave port
`timescale 1ns/1ps
`include "wb_bus_cfg.svh"

module wb_bus_top (
    input  logic                      clk,
    input  logic                      reset,

    input  logic [`WB_M*`WB_AW-1:0]   m_adr_i,
    input  logic [`WB_M*`WB_DW-1:0]   m_dat_i,
    input  logic [`WB_M*`WB_SELW-1:0] m_sel_i,
    input  wb_pkg::mst_vec_t          m_we_i,
    input  wb_pkg::mst_vec_t          m_cyc_i,
    input  wb_pkg::mst_vec_t          m_stb_i,
    output logic [`WB_M*`WB_DW-1:0]   m_dat_o,
    output wb_pkg::mst_vec_t          m_ack_o,
    output wb_pkg::mst_vec_t          m_err_o,

    output wb_pkg::addr_t             snoop_adr_o,
    output logic                      snoop_en_o
);

    wb_pkg::addr_t              grant_adr;
    wb_pkg::slv_vec_t           sel_onehot;
    logic                       addr_miss;
    wb_pkg::addr_t              s_adr;
    wb_pkg::data_t              s_dat_w;
    wb_pkg::sel_t               s_sel;
    logic                       s_we;
    wb_pkg::slv_vec_t           s_cyc;
    wb_pkg::slv_vec_t           s_stb;
    logic [`WB_S*`WB_DW-1:0]    s_dat_r;
    wb_pkg::slv_vec_t           s_ack;

    wb_shared_bus u_bus (
        .clk            (clk),
        .reset          (reset),
        .m_adr_i        (m_adr_i),
        .m_dat_i        (m_dat_i),
        .m_sel_i        (m_sel_i),
        .m_we_i         (m_we_i),
        .m_cyc_i        (m_cyc_i),
        .m_stb_i        (m_stb_i),
        .m_dat_o        (m_dat_o),
        .m_ack_o        (m_ack_o),
        .m_err_o        (m_err_o),
        .grant_adr_o    (grant_adr),
        .s_sel_onehot_i (sel_onehot),
        .addr_miss_i    (addr_miss),
        .s_adr_o        (s_adr),
        .s_dat_o        (s_dat_w),
        .s_sel_o        (s_sel),
        .s_we_o         (s_we),
        .s_cyc_o        (s_cyc),
        .s_stb_o        (s_stb),
        .s_dat_i        (s_dat_r),
        .s_ack_i        (s_ack),
        .snoop_adr_o    (snoop_adr_o),
        .snoop_en_o     (snoop_en_o)
    );

    wb_addr_decoder u_decoder (
        .adr_i        (grant_adr),
        .sel_onehot_o (sel_onehot),
        .miss_o       (addr_miss)
    );

    // one memory per window
    for (genvar k = 0; k < `WB_S; k++) begin : g_ram
        wb_ram_slave u_ram (
            .clk    (clk),
            .reset  (reset),
            .cyc_i  (s_cyc[k]),
            .stb_i  (s_stb[k]),
            .we_i   (s_we),
            .adr_i  (s_adr),
            .dat_i  (s_dat_w),
            .sel_i  (s_sel),
            .dat_o  (s_dat_r[k*`WB_DW +: `WB_DW]),
            .ack_o  (s_ack[k])
        );
    end

endmodule

/* source/wb_ram_slave.sv */
// wishbone ram slave with byte selects and registered single-cycle ack
`timescale 1ns/1ps
`include "wb_bus_cfg.svh"

module wb_ram_slave (
    input  logic          clk,
    input  logic          reset,
    input  logic          cyc_i,
    input  logic          stb_i,
    input  logic          we_i,
    input  wb_pkg::addr_t adr_i,
    input  wb_pkg::data_t dat_i,
    input  wb_pkg::sel_t  sel_i,
    output wb_pkg::data_t dat_o,
    output logic          ack_o
);

    localparam int IW = $clog2(`WB_RAM_WORDS);

    wb_pkg::data_t  mem [0:`WB_RAM_WORDS-1];
    logic [IW-1:0]  idx;
    logic           access;
    logic           ack_q;

    // word offset inside the window
    assign idx = adr_i[IW+1:2];

    // accepted on the edge that raises ack and never twice per strobe
    assign access = cyc_i & stb_i & ~ack_q;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            for (int b = 0; b < `WB_SELW; b++) begin
                if (we_i && sel_i[b]) begin
                    mem[idx][8*b +: 8] <= dat_i[8*b +: 8];
                end
            end
            dat_o <= mem[idx];
        end
    end

    assign ack_o = ack_q;

    // the strobe must still be held while ack answers it
    ack_with_stb_a: assert property (@(posedge clk) disable iff (reset)
        ack_o |-> (cyc_i && stb_i));

endmodule

/* source/wb_shared_bus.sv */
// shared wishbone bus: master mux, slave strobes, response routing and snoop port
`timescale 1ns/1ps
`include "wb_bus_cfg.svh"

module wb_shared_bus (
    input  logic                          clk,
    input  logic                          reset,

    // master side
    input  logic [`WB_M*`WB_AW-1:0]       m_adr_i,
    input  logic [`WB_M*`WB_DW-1:0]       m_dat_i,
    input  logic [`WB_M*`WB_SELW-1:0]     m_sel_i,
    input  wb_pkg::mst_vec_t              m_we_i,
    input  wb_pkg::mst_vec_t              m_cyc_i,
    input  wb_pkg::mst_vec_t              m_stb_i,
    output logic [`WB_M*`WB_DW-1:0]       m_dat_o,
    output wb_pkg::mst_vec_t              m_ack_o,
    output wb_pkg::mst_vec_t              m_err_o,

    // decoder
    output wb_pkg::addr_t                 grant_adr_o,
    input  wb_pkg::slv_vec_t              s_sel_onehot_i,
    input  logic                          addr_miss_i,

    // slave side
    output wb_pkg::addr_t                 s_adr_o,
    output wb_pkg::data_t                 s_dat_o,
    output wb_pkg::sel_t                  s_sel_o,
    output logic                          s_we_o,
    output wb_pkg::slv_vec_t              s_cyc_o,
    output wb_pkg::slv_vec_t              s_stb_o,
    input  logic [`WB_S*`WB_DW-1:0]       s_dat_i,
    input  wb_pkg::slv_vec_t              s_ack_i,

    // write snoop
    output wb_pkg::addr_t                 snoop_adr_o,
    output logic                          snoop_en_o
);

    wb_pkg::mst_vec_t grant;
    wb_pkg::addr_t    g_adr;
    wb_pkg::data_t    g_dat;
    wb_pkg::sel_t     g_sel;
    logic             g_we;
    logic             g_cyc;
    logic             g_stb;
    wb_pkg::data_t    rd_dat;
    logic             any_ack;
    logic             miss_err;

    wb_arbiter u_arbiter (
        .clk     (clk),
        .reset   (reset),
        .req_i   (m_cyc_i),
        .grant_o (grant)
    );

    // payload of the granted master, zero when idle
    always_comb begin
        g_adr = '0;
        g_dat = '0;
        g_sel = '0;
        g_we  = 1'b0;
        for (int i = 0; i < `WB_M; i++) begin
            if (grant[i]) begin
                g_adr = m_adr_i[i*`WB_AW +: `WB_AW];
                g_dat = m_dat_i[i*`WB_DW +: `WB_DW];
                g_sel = m_sel_i[i*`WB_SELW +: `WB_SELW];
                g_we  = m_we_i[i];
            end
        end
    end

    // control is masked by the grant so an idle bus drives nothing
    assign g_cyc = |(m_cyc_i & grant);
    assign g_stb = |(m_stb_i & grant);

    assign grant_adr_o = g_adr;
    assign s_adr_o     = g_adr;
    assign s_dat_o     = g_dat;
    assign s_sel_o     = g_sel;
    assign s_we_o      = g_we;
    assign s_cyc_o     = {`WB_S{g_cyc}};
    assign s_stb_o     = s_sel_onehot_i & {`WB_S{g_cyc & g_stb}};

    // read data from the addressed slave
    always_comb begin
        rd_dat = '0;
        for (int k = 0; k < `WB_S; k++) begin
            if (s_sel_onehot_i[k]) begin
                rd_dat = s_dat_i[k*`WB_DW +: `WB_DW];
            end
        end
    end

    assign any_ack  = |s_ack_i;
    // unmapped access answers at once, no slave involved
    assign miss_err = g_cyc & g_stb & addr_miss_i;

    assign m_ack_o = grant & {`WB_M{any_ack}};
    assign m_err_o = grant & {`WB_M{miss_err}};

    always_comb begin
        for (int i = 0; i < `WB_M; i++) begin
            m_dat_o[i*`WB_DW +: `WB_DW] = grant[i] ? rd_dat : '0;
        end
    end

    // acked write, for cache invalidation elsewhere
    assign snoop_adr_o = g_adr;
    assign snoop_en_o  = any_ack & g_stb & g_we;

    slave_stb_onehot_a: assert property (@(posedge clk) disable iff (reset) $onehot0(s_stb_o));

endmodule

/* source/wb_addr_decoder.sv */
// address decoder, granted address to one-hot slave select and miss flag
`timescale 1ns/1ps
`include "wb_bus_cfg.svh"

module wb_addr_decoder (
    input  wb_pkg::addr_t    adr_i,
    output wb_pkg::slv_vec_t sel_onehot_o,
    output logic             miss_o
);

    // bytes actually backed by memory in each window
    localparam wb_pkg::addr_t WINDOW_BYTES = wb_pkg::addr_t'(4 * `WB_RAM_WORDS);

    always_comb begin
        wb_pkg::addr_t base;
        wb_pkg::addr_t offset;
        sel_onehot_o = '0;
        for (int k = 0; k < `WB_S; k++) begin
            base   = wb_pkg::slave_base(k);
            offset = adr_i - base;
            // offset compare avoids overflow at the top of the map
            if (adr_i >= base && offset < WINDOW_BYTES) begin
                sel_onehot_o[k] = 1'b1;
            end
        end
    end

    // nothing matched, the bus turns this into err
    assign miss_o = ~|sel_onehot_o;

endmodule

/* source/wb_arbiter.sv */
// round-robin bus arbiter with registered one-hot grant
`timescale 1ns/1ps
`include "wb_bus_cfg.svh"

module wb_arbiter (
    input  logic             clk,
    input  logic             reset,
    input  wb_pkg::mst_vec_t req_i,
    output wb_pkg::mst_vec_t grant_o
);

    localparam int PW = (`WB_M > 1) ? $clog2(`WB_M) : 1;

    wb_pkg::mst_vec_t grant_q;
    wb_pkg::mst_vec_t pick;
    logic [PW-1:0]    ptr_q;
    int               pick_idx;
    logic             held;

    // granted master still in its cycle
    assign held = |(grant_q & req_i);

    // first requester at or after the pointer
    always_comb begin
        int  idx;
        logic found;
        pick     = '0;
        pick_idx = 0;
        found    = 1'b0;
        for (int i = 0; i < `WB_M; i++) begin
            idx = (int'(ptr_q) + i) % `WB_M;
            if (!found && req_i[idx]) begin
                pick[idx] = 1'b1;
                pick_idx  = idx;
                found     = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            grant_q <= '0;
            ptr_q   <= '0;
        end else if (grant_q == '0) begin
            grant_q <= pick;
            // next search starts just past the winner
            if (pick != '0) begin
                ptr_q <= (pick_idx == `WB_M - 1) ? '0 : PW'(pick_idx + 1);
            end
        end else if (!held) begin
            // release for one idle cycle before the next grant
            grant_q <= '0;
        end
    end

    assign grant_o = grant_q;

    grant_onehot_a: assert property (@(posedge clk) disable iff (reset) $onehot0(grant_q));

endmodule

/* source/wb_pkg.sv */
// wishbone bus types and address map helper
`include "wb_bus_cfg.svh"

package wb_pkg;

    // bus payload types
    typedef logic [`WB_AW-1:0]   addr_t;
    typedef logic [`WB_DW-1:0]   data_t;
    typedef logic [`WB_SELW-1:0] sel_t;

    // one bit per port
    typedef logic [`WB_M-1:0] mst_vec_t;
    typedef logic [`WB_S-1:0] slv_vec_t;

    // base address of slave k, windows are spaced WB_SLAVE_SPAN apart
    function automatic addr_t slave_base(input int unsigned k);
        addr_t base;
        base = addr_t'(k) * addr_t'(`WB_SLAVE_SPAN);
        return base;
    endfunction

endpackage

/* source/wb_bus_cfg.svh */
// bus widths, port counts and slave memory size for the wishbone interconnect
`ifndef WB_BUS_CFG_SVH
`define WB_BUS_CFG_SVH

// address and data widths
`define WB_AW 32
`define WB_DW 32

// one select bit per data byte
`define WB_SELW (`WB_DW / 8)

// number of masters and slaves on the shared bus
`define WB_M 2
`define WB_S 3

// words held by each ram slave
`define WB_RAM_WORDS 256

// byte distance between two slave windows
`define WB_SLAVE_SPAN 32'h1000

`endif
